// ==== fetch_pkg.sv ====
// Shared widths, tag and state encodings and memory constants for the instruction fetch path
package fetch_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Byte address of an instruction word
	localparam int unsigned ADDR_W = 32;
	// One instruction word
	localparam int unsigned DATA_W = 32;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////

	// Error tags returned by a bank with err high
	typedef enum logic [3:0] {
		ITAG_NONE = 4'h0,
		// Bus error
		ITAG_BE   = 4'hb,
		// Page fault
		ITAG_PE   = 4'hc,
		// TLB miss
		ITAG_TE   = 4'hd
	} itag_e;

	// Four-phase request sequencer states
	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_WAIT_ACK,
		REQ_WAIT_RELEASE
	} req_state_e;

	////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////

	// l.nop with the fetch-error immediate
	localparam logic [DATA_W-1:0] NOP_INSN = {6'b000101, 26'h041_0000};
	// Bank content is the address XOR this pattern
	localparam logic [DATA_W-1:0] INSN_XOR = 32'hA5A5_0F0F;
	// Top nibble that marks the faulting region
	localparam logic [3:0] ERR_REGION = 4'hF;

endpackage

// ==== fetch_bank_if.sv ====
// Four-phase req/ack link between the fetch request generator and one instruction bank
`timescale 1ns/1ps

interface fetch_bank_if;

	// Request phase, driven by the generator
	logic                            req;
	logic [fetch_pkg::ADDR_W-1:0]    addr;

	// Response phase, valid while ack is high
	logic                            ack;
	logic [fetch_pkg::DATA_W-1:0]    data;
	logic                            err;
	fetch_pkg::itag_e                tag;

	// Generator side
	modport requester (
		output req, addr,
		input  ack
	);

	// Bank side
	modport responder (
		input  req, addr,
		output ack, data, err, tag
	);

	// Response collector, observes only
	modport monitor (
		input ack, data, err, tag, addr
	);

endinterface

// ==== fetch_req_gen.sv ====
// Program counter and four-phase request sequencer that issues one fetch at a time to the banks
`timescale 1ns/1ps

module fetch_req_gen #(
	parameter int unsigned                   NUM_BANKS = 4,
	parameter logic [fetch_pkg::ADDR_W-1:0]  RESET_PC  = 32'h0000_0100
) (
	input  logic                             clk,
	input  logic                             rst_i,
	input  logic                             flush_i,
	input  logic [fetch_pkg::ADDR_W-1:0]     target_i,
	input  logic                             hold_i,
	output logic                             discard_o,
	fetch_bank_if.requester                  bank [NUM_BANKS]
);

	// Word-index bits that pick a bank
	localparam int unsigned SEL_W = $clog2(NUM_BANKS);

	fetch_pkg::req_state_e           state_q;
	logic [fetch_pkg::ADDR_W-1:0]    pc_q;
	logic [fetch_pkg::ADDR_W-1:0]    addr_q;
	logic [SEL_W-1:0]                sel_q;
	logic                            req_q;
	logic                            discard_q;
	logic [NUM_BANKS-1:0]            ack_vec;
	logic                            ack_any;
	logic                            ack_sel;
	logic                            busy;
	logic                            start;

	////////////////////////////////////////////////////////////
	// Per-bank links
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_link
		logic hit;
		// Only the latched bank sees req and addr
		assign hit          = (sel_q == SEL_W'(g));
		assign bank[g].req  = req_q & hit;
		assign bank[g].addr = hit ? addr_q : '0;
		assign ack_vec[g]   = bank[g].ack;
	end

	assign ack_any = |ack_vec;
	assign ack_sel = ack_vec[sel_q];
	assign busy    = (state_q != fetch_pkg::REQ_IDLE);

	// New fetch only once the previous ack is gone and nothing is parked
	assign start = (state_q == fetch_pkg::REQ_IDLE) & ~flush_i & ~hold_i & ~ack_any;

	// Flush in the ack cycle must already kill the response
	assign discard_o = discard_q | (flush_i & busy);

	////////////////////////////////////////////////////////////
	// Handshake FSM and PC
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q   <= fetch_pkg::REQ_IDLE;
			req_q     <= 1'b0;
			sel_q     <= '0;
			discard_q <= 1'b0;
			pc_q      <= RESET_PC;
		end else begin
			case (state_q)
				fetch_pkg::REQ_IDLE: begin
					if (start) begin
						req_q   <= 1'b1;
						sel_q   <= pc_q[2 +: SEL_W];
						state_q <= fetch_pkg::REQ_WAIT_ACK;
					end
				end
				fetch_pkg::REQ_WAIT_ACK: begin
					// Drop req the cycle after ack
					if (ack_sel) begin
						req_q   <= 1'b0;
						state_q <= fetch_pkg::REQ_WAIT_RELEASE;
					end
				end
				fetch_pkg::REQ_WAIT_RELEASE: begin
					if (!ack_sel)
						state_q <= fetch_pkg::REQ_IDLE;
				end
				default: state_q <= fetch_pkg::REQ_IDLE;
			endcase

			// Redirect wins over sequential advance
			if (flush_i)
				pc_q <= target_i;
			else if (state_q == fetch_pkg::REQ_WAIT_ACK && ack_sel && !discard_q)
				pc_q <= pc_q + fetch_pkg::ADDR_W'(4);

			// Stale until the flushed transaction releases ack
			if (state_q == fetch_pkg::REQ_WAIT_RELEASE && !ack_sel)
				discard_q <= 1'b0;
			else if (flush_i && busy)
				discard_q <= 1'b1;
		end
	end

	// Address held stable for the whole transaction
	always_ff @(posedge clk) begin
		if (start)
			addr_q <= pc_q;
	end

endmodule

// ==== fetch_bank.sv ====
// One instruction bank that answers a four-phase request after an address-dependent latency
`timescale 1ns/1ps

module fetch_bank #(
	// Identifies the bank in the hierarchy
	parameter int unsigned BANK_INDEX = 0
) (
	input  logic                clk,
	input  logic                rst_i,
	fetch_bank_if.responder     link
);

	logic                            busy_q;
	logic [1:0]                      cnt_q;
	logic                            ack_q;
	logic [fetch_pkg::DATA_W-1:0]    data_q;
	logic                            err_q;
	fetch_pkg::itag_e                tag_q;
	logic                            in_err_region;
	fetch_pkg::itag_e                err_tag;
	logic                            done;

	// Top nibble selects the faulting region
	assign in_err_region = (link.addr[fetch_pkg::ADDR_W-1 -: 4] == fetch_pkg::ERR_REGION);

	// Bits 27:26 choose the kind of fault
	always_comb begin
		case (link.addr[27:26])
			2'b01:   err_tag = fetch_pkg::ITAG_PE;
			2'b10:   err_tag = fetch_pkg::ITAG_TE;
			default: err_tag = fetch_pkg::ITAG_BE;
		endcase
	end

	// Latency counter has run out
	assign done = busy_q & (cnt_q == 2'd0);

	////////////////////////////////////////////////////////////
	// Latency and ack
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			cnt_q  <= 2'd0;
			ack_q  <= 1'b0;
		end else begin
			if (!busy_q && !ack_q && link.req) begin
				// Bits 5:4 give 1 to 4 cycles
				busy_q <= 1'b1;
				cnt_q  <= link.addr[5:4];
			end else if (done) begin
				busy_q <= 1'b0;
				ack_q  <= 1'b1;
			end else if (busy_q) begin
				cnt_q <= cnt_q - 2'd1;
			end else if (ack_q && !link.req) begin
				ack_q <= 1'b0;
			end
		end
	end

	// Response word, held while ack is high
	always_ff @(posedge clk) begin
		if (done) begin
			data_q <= in_err_region ? '0 : (link.addr ^ fetch_pkg::INSN_XOR);
			err_q  <= in_err_region;
			tag_q  <= in_err_region ? err_tag : fetch_pkg::ITAG_NONE;
		end
	end

	assign link.ack  = ack_q;
	assign link.data = data_q;
	assign link.err  = err_q;
	assign link.tag  = tag_q;

endmodule

// ==== fetch_resp_mux.sv ====
// Merges the bank acknowledges into one registered response pulse for the fetch stage
`timescale 1ns/1ps

module fetch_resp_mux #(
	parameter int unsigned NUM_BANKS = 4
) (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            discard_i,
	fetch_bank_if.monitor                   bank [NUM_BANKS],
	output logic                            rsp_valid_o,
	output logic [fetch_pkg::DATA_W-1:0]    rsp_data_o,
	output logic                            rsp_err_o,
	output fetch_pkg::itag_e                rsp_tag_o,
	output logic [fetch_pkg::ADDR_W-1:0]    rsp_pc_o
);

	logic [NUM_BANKS-1:0]                   ack_vec;
	logic [NUM_BANKS-1:0]                   err_vec;
	logic [fetch_pkg::DATA_W-1:0]           data_vec [NUM_BANKS];
	logic [fetch_pkg::ADDR_W-1:0]           addr_vec [NUM_BANKS];
	logic [3:0]                             tag_vec  [NUM_BANKS];
	logic                                   ack_any;
	logic                                   ack_any_q;
	logic                                   ack_rise;
	logic [fetch_pkg::DATA_W-1:0]           data_or;
	logic [fetch_pkg::ADDR_W-1:0]           addr_or;
	logic [3:0]                             tag_or;
	logic                                   err_or;

	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_tap
		assign ack_vec[g]  = bank[g].ack;
		assign err_vec[g]  = bank[g].err;
		assign data_vec[g] = bank[g].data;
		assign addr_vec[g] = bank[g].addr;
		assign tag_vec[g]  = bank[g].tag;
	end

	// Acks are one-hot, so AND-OR selects the active bank
	always_comb begin
		data_or = '0;
		addr_or = '0;
		tag_or  = '0;
		err_or  = 1'b0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			data_or = data_or | (data_vec[i] & {fetch_pkg::DATA_W{ack_vec[i]}});
			addr_or = addr_or | (addr_vec[i] & {fetch_pkg::ADDR_W{ack_vec[i]}});
			tag_or  = tag_or | (tag_vec[i] & {4{ack_vec[i]}});
			err_or  = err_or | (err_vec[i] & ack_vec[i]);
		end
	end

	assign ack_any  = |ack_vec;
	assign ack_rise = ack_any & ~ack_any_q;

	////////////////////////////////////////////////////////////
	// Response pulse
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_any_q   <= 1'b0;
			rsp_valid_o <= 1'b0;
		end else begin
			ack_any_q   <= ack_any;
			// Stale responses after a flush never pulse
			rsp_valid_o <= ack_rise & ~discard_i;
		end
	end

	// Payload captured once per transaction
	always_ff @(posedge clk) begin
		if (ack_rise) begin
			rsp_data_o <= data_or;
			rsp_err_o  <= err_or;
			rsp_tag_o  <= fetch_pkg::itag_e'(tag_or);
			rsp_pc_o   <= addr_or;
		end
	end

endmodule

// ==== fetch_if_stage.sv ====
// Fetch stage that parks a response under freeze, substitutes NOPs on errors and raises exceptions
`timescale 1ns/1ps

module fetch_if_stage (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            freeze_i,
	input  logic                            flush_i,
	input  logic                            rsp_valid_i,
	input  logic                            rsp_err_i,
	input  logic [fetch_pkg::DATA_W-1:0]    rsp_data_i,
	input  fetch_pkg::itag_e                rsp_tag_i,
	input  logic [fetch_pkg::ADDR_W-1:0]    rsp_pc_i,
	output logic                            hold_o,
	output logic                            valid_o,
	output logic [fetch_pkg::DATA_W-1:0]    insn_o,
	output logic [fetch_pkg::ADDR_W-1:0]    pc_o,
	output logic                            except_itlbmiss_o,
	output logic                            except_immufault_o,
	output logic                            except_ibuserr_o
);

	logic                            saved_q;
	logic [fetch_pkg::DATA_W-1:0]    insn_saved_q;
	logic [fetch_pkg::ADDR_W-1:0]    addr_saved_q;
	// Bit 0 TLB miss, bit 1 page fault, bit 2 bus error
	logic [2:0]                      err_saved_q;
	logic [2:0]                      err_live;
	logic [2:0]                      err_sel;
	logic [fetch_pkg::DATA_W-1:0]    insn_live;
	logic                            save_insn;

	////////////////////////////////////////////////////////////
	// Live response decode
	////////////////////////////////////////////////////////////

	assign err_live[0] = rsp_err_i & (rsp_tag_i == fetch_pkg::ITAG_TE);
	assign err_live[1] = rsp_err_i & (rsp_tag_i == fetch_pkg::ITAG_PE);
	assign err_live[2] = rsp_err_i & (rsp_tag_i == fetch_pkg::ITAG_BE);

	// Faulting fetch turns into a NOP
	assign insn_live = rsp_err_i ? fetch_pkg::NOP_INSN : rsp_data_i;

	// Park a response that arrives while frozen, unless it is being flushed
	assign save_insn = rsp_valid_i & freeze_i & ~saved_q & ~flush_i;

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Parked instruction stops further fetches
	assign hold_o = saved_q;

	assign valid_o = (rsp_valid_i | saved_q) & ~freeze_i & ~flush_i;

	// Saved copy has priority over the live response
	assign insn_o  = saved_q ? insn_saved_q : insn_live;
	assign pc_o    = saved_q ? addr_saved_q : rsp_pc_i;
	assign err_sel = saved_q ? err_saved_q : err_live;

	// Exceptions only accompany a delivery
	assign except_itlbmiss_o  = valid_o & err_sel[0];
	assign except_immufault_o = valid_o & err_sel[1];
	assign except_ibuserr_o   = valid_o & err_sel[2];

	////////////////////////////////////////////////////////////
	// Saved instruction
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i)
			saved_q <= 1'b0;
		else if (flush_i)
			saved_q <= 1'b0;
		else if (save_insn)
			saved_q <= 1'b1;
		else if (!freeze_i)
			// Delivered this cycle
			saved_q <= 1'b0;
	end

	// Word, address and decoded flags travel together
	always_ff @(posedge clk) begin
		if (save_insn) begin
			insn_saved_q <= insn_live;
			addr_saved_q <= rsp_pc_i;
			err_saved_q  <= err_live;
		end
	end

endmodule

// ==== fetch_top.sv ====
// Top level of the fetch path, wiring the generator, the bank array, the collector and the stage
`timescale 1ns/1ps

module fetch_top #(
	parameter int unsigned                   NUM_BANKS = 4,
	parameter logic [fetch_pkg::ADDR_W-1:0]  RESET_PC  = 32'h0000_0100
) (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            freeze_i,
	input  logic                            flush_i,
	input  logic [fetch_pkg::ADDR_W-1:0]    target_i,
	output logic                            valid_o,
	output logic [fetch_pkg::DATA_W-1:0]    insn_o,
	output logic [fetch_pkg::ADDR_W-1:0]    pc_o,
	output logic                            except_itlbmiss_o,
	output logic                            except_immufault_o,
	output logic                            except_ibuserr_o
);

	// Generator to collector
	logic                            discard;
	// Collector to stage
	logic                            rsp_valid;
	logic [fetch_pkg::DATA_W-1:0]    rsp_data;
	logic                            rsp_err;
	fetch_pkg::itag_e                rsp_tag;
	logic [fetch_pkg::ADDR_W-1:0]    rsp_pc;
	// Stage back to generator
	logic                            hold;

	// One link per bank
	fetch_bank_if bank_link [NUM_BANKS] ();

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	fetch_req_gen #(
		.NUM_BANKS (NUM_BANKS),
		.RESET_PC  (RESET_PC)
	) u_req_gen (
		.clk       (clk),
		.rst_i     (rst_i),
		.flush_i   (flush_i),
		.target_i  (target_i),
		.hold_i    (hold),
		.discard_o (discard),
		.bank      (bank_link)
	);

	// Banks interleaved on the low word-index bits
	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		fetch_bank #(
			.BANK_INDEX (g)
		) u_bank (
			.clk   (clk),
			.rst_i (rst_i),
			.link  (bank_link[g])
		);
	end

	////////////////////////////////////////////////////////////
	// Response side
	////////////////////////////////////////////////////////////

	fetch_resp_mux #(
		.NUM_BANKS (NUM_BANKS)
	) u_resp_mux (
		.clk         (clk),
		.rst_i       (rst_i),
		.discard_i   (discard),
		.bank        (bank_link),
		.rsp_valid_o (rsp_valid),
		.rsp_data_o  (rsp_data),
		.rsp_err_o   (rsp_err),
		.rsp_tag_o   (rsp_tag),
		.rsp_pc_o    (rsp_pc)
	);

	fetch_if_stage u_if_stage (
		.clk                (clk),
		.rst_i              (rst_i),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.rsp_valid_i        (rsp_valid),
		.rsp_err_i          (rsp_err),
		.rsp_data_i         (rsp_data),
		.rsp_tag_i          (rsp_tag),
		.rsp_pc_i           (rsp_pc),
		.hold_o             (hold),
		.valid_o            (valid_o),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

// ==== tb_fetch_top.sv ====
// Self-checking testbench for the fetch path top level, driving random freeze and flush traffic
`timescale 1ns/1ps

module tb_fetch_top;

	// Values from the fetch path rules
	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam logic [31:0] XOR_PATTERN = 32'hA5A5_0F0F;
	localparam logic [3:0] ERR_NIBBLE = 4'hF;
	localparam int NUM_DELIVERIES = 2000;
	localparam int DELIVERY_TIMEOUT = 500;
	localparam int RESET_CYCLES = 16;

	logic clk = 1'b0;
	logic rst_i;
	logic freeze_i;
	logic flush_i;
	logic [31:0] target_i;
	logic valid_o;
	logic [31:0] insn_o;
	logic [31:0] pc_o;
	logic except_itlbmiss_o;
	logic except_immufault_o;
	logic except_ibuserr_o;

	// Model state and counters
	logic [31:0] exp_pc;
	string check_name;
	bit delivered;
	bit timed_out;
	int deliveries;
	int flushes;
	int frozen_cycles;
	int errors;

	fetch_top u_dut (
		.clk                (clk),
		.rst_i              (rst_i),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.target_i           (target_i),
		.valid_o            (valid_o),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

	// 100 ns period
	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Instruction word the memory holds at a fetch address
	function automatic logic [31:0] expected_insn(input logic [31:0] pc);
		if (pc[31:28] == ERR_NIBBLE)
			return fetch_pkg::NOP_INSN;
		return pc ^ XOR_PATTERN;
	endfunction

	// Bit 2 bus error, bit 1 page fault, bit 0 TLB miss
	function automatic logic [2:0] expected_exc(input logic [31:0] pc);
		logic [2:0] exc;
		exc = 3'b000;
		if (pc[31:28] == ERR_NIBBLE) begin
			case (pc[27:26])
				2'b01:   exc = 3'b010;
				2'b10:   exc = 3'b001;
				default: exc = 3'b100;
			endcase
		end
		return exc;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("Error %s: expected %08h, actual %08h at %0t", name, exp, act, $time);
	endtask

	////////////////////////////////////////////////////////////
	// Per-cycle check, run mid-cycle on settled values
	////////////////////////////////////////////////////////////

	task automatic check_cycle();
		logic [2:0] act_exc;
		act_exc = {except_ibuserr_o, except_immufault_o, except_itlbmiss_o};
		delivered = 1'b0;
		if (freeze_i)
			frozen_cycles++;
		if (valid_o !== 1'b0 && valid_o !== 1'b1) begin
			errors++;
			$display("valid_o is unknown at %0t", $time);
		end else if (valid_o && freeze_i) begin
			errors++;
			$display("Instruction delivered while freeze_i was high at %0t", $time);
		end else if (valid_o && flush_i) begin
			errors++;
			$display("Instruction delivered while flush_i was high at %0t", $time);
		end else if (valid_o) begin
			if (pc_o !== exp_pc)
				report_mismatch(check_name, exp_pc, pc_o);
			if (insn_o !== expected_insn(exp_pc))
				report_mismatch("insn_content", expected_insn(exp_pc), insn_o);
			if (act_exc !== expected_exc(exp_pc))
				report_mismatch("except_flags", 32'(expected_exc(exp_pc)), 32'(act_exc));
			deliveries++;
			delivered = 1'b1;
			exp_pc = exp_pc + 32'd4;
			check_name = "sequential_pc";
		end
		// Exceptions only ride along with a delivery
		if (valid_o !== 1'b1 && act_exc !== 3'b000) begin
			errors++;
			$display("Exception output high without a delivery at %0t", $time);
		end
		// Redirect applies after this cycle's delivery
		if (flush_i) begin
			exp_pc = target_i;
			check_name = "flush_target";
			flushes++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Freeze in bursts near 30 %, flush near 3 %
	task automatic drive_inputs();
		logic [31:0] t;
		if (freeze_i) begin
			if ($urandom % 4 == 0)
				freeze_i = 1'b0;
		end else if ($urandom % 100 < 11) begin
			freeze_i = 1'b1;
		end
		// First fetch runs without redirect so the reset PC is seen
		flush_i = (deliveries > 0) && ($urandom % 100 < 3);
		if (flush_i) begin
			t = $urandom;
			t[1:0] = 2'b00;
			// A quarter of targets fault
			if ($urandom % 4 == 0)
				t[31:28] = ERR_NIBBLE;
			else if (t[31:28] == ERR_NIBBLE)
				t[31] = 1'b0;
			target_i = t;
		end
	endtask

	// Runs cycles until one instruction is delivered
	task automatic wait_delivery();
		int waited;
		waited = 0;
		delivered = 1'b0;
		while (!delivered && waited < DELIVERY_TIMEOUT) begin
			@(negedge clk);
			check_cycle();
			@(posedge clk);
			#1;
			drive_inputs();
			waited++;
		end
		if (!delivered) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout: no instruction delivered within %0d cycles, request FSM in %s",
				DELIVERY_TIMEOUT, u_dut.u_req_gen.state_q.name());
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(29));
		rst_i = 1'b1;
		freeze_i = 1'b0;
		flush_i = 1'b0;
		target_i = '0;
		exp_pc = RESET_PC;
		check_name = "reset_pc";
		delivered = 1'b0;
		timed_out = 1'b0;
		deliveries = 0;
		flushes = 0;
		frozen_cycles = 0;
		errors = 0;

		// Outputs must stay quiet through reset
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#1;
			if (valid_o !== 1'b0 || except_itlbmiss_o !== 1'b0 ||
				except_immufault_o !== 1'b0 || except_ibuserr_o !== 1'b0) begin
				errors++;
				$display("Output active during reset at %0t", $time);
			end
		end
		rst_i = 1'b0;

		while (deliveries < NUM_DELIVERIES && !timed_out)
			wait_delivery();

		$display("Deliveries %0d, flushes %0d, frozen cycles %0d, errors %0d",
			deliveries, flushes, frozen_cycles, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== fetch_top.f ====
fetch_pkg.sv
fetch_bank_if.sv
fetch_req_gen.sv
fetch_bank.sv
fetch_resp_mux.sv
fetch_if_stage.sv
fetch_top.sv
tb_fetch_top.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
RTL_TOP    = fetch_top
TB_TOP     = tb_fetch_top
FILELIST   = fetch_top.f
OBJ_DIR    = obj_dir
PASS_MSG   = No errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
